// File: Bender.yml
package:
  name: risc_core

sources:
  - logic/riscPkg.sv
  - logic/coreIfs.sv
  - logic/stageSequencer.sv
  - logic/programCounter.sv
  - logic/fetchUnit.sv
  - logic/decodeUnit.sv
  - logic/regFile.sv
  - logic/executeUnit.sv
  - logic/dataMemory.sv
  - logic/riscCore.sv
  - target: test
    files:
      - tests/riscCoreTb.sv

// File: logic/coreIfs.sv
`default_nettype none

interface stageIf;
	logic fetch; // Instruction register load.
	logic read; // Register file read.
	logic exec; // ALU and flags.
	logic mem; // Data RAM access.
	logic wb; // Register write-back.

	modport seq (
		output fetch, read, exec, mem, wb
	);

	modport unit (
		input fetch, read, exec, mem, wb
	);
endinterface

interface ctrlIf;
	import riscPkg::*;

	logic aluNand; // NAND instead of add.
	logic useImm; // Immediate as second operand.
	logic flagEn; // Flags follow the ALU.
	logic [1:0] cond; // Write condition code.
	logic [1:0] wbSel; // Write-back source.
	logic rfWe; // Instruction writes a register.
	logic memWe; // Instruction stores.
	logic [REG_AW-1:0] destAddr; // Target register.

	modport dec (
		output aluNand, useImm, flagEn, cond, wbSel, rfWe, memWe, destAddr
	);

	modport exe (
		input aluNand, useImm, flagEn, cond, wbSel, rfWe, memWe, destAddr
	);
endinterface

`default_nettype wire

// File: logic/dataMemory.sv
`default_nettype none

module dataMemory #(
	parameter int DMEM_AW = 8
) (
	input logic clk,
	stageIf.unit stg,
	input logic i_we,
	input logic [DMEM_AW-1:0] i_addr,
	input logic [riscPkg::DATA_W-1:0] i_wdata,
	output logic [riscPkg::DATA_W-1:0] o_rdata
);
	import riscPkg::*;

	logic [DATA_W-1:0] ram [2**DMEM_AW]; // Contents survive reset.

	always_ff @(posedge clk) begin
		if (stg.mem) begin
			if (i_we) begin
				ram[i_addr] <= i_wdata;
			end
			o_rdata <= ram[i_addr]; // Ready for write-back.
		end
	end

endmodule

`default_nettype wire

// File: logic/decodeUnit.sv
`default_nettype none

module decodeUnit (
	input logic clk,
	input logic rst,
	input riscPkg::instrWord_u i_instr,
	stageIf.unit stg,
	ctrlIf.dec ctl,
	output logic [riscPkg::REG_AW-1:0] o_rdAddrA,
	output logic [riscPkg::REG_AW-1:0] o_rdAddrB,
	output logic [riscPkg::DATA_W-1:0] o_imm
);
	import riscPkg::*;

	logic nAluNand, nUseImm, nFlagEn, nRfWe, nMemWe;
	logic [1:0] nCond, nWbSel;
	logic [REG_AW-1:0] nDest;
	logic [DATA_W-1:0] immSext, immHigh;

	assign immSext = {{(DATA_W - 6){i_instr.iFmt.imm6[5]}}, i_instr.iFmt.imm6}; // ADI, LW, SW.
	assign immHigh = {i_instr.jFmt.imm9, {(DATA_W - 9){1'b0}}}; // LHI.

	always_comb begin
		nAluNand = 1'b0;
		nUseImm = 1'b0;
		nFlagEn = 1'b0;
		nCond = COND_ALWAYS;
		nWbSel = WB_ALU;
		nRfWe = 1'b0; // Unknown opcodes fall through as no-ops.
		nMemWe = 1'b0;
		nDest = i_instr.rFmt.rc;
		o_rdAddrA = i_instr.rFmt.ra;
		o_rdAddrB = i_instr.rFmt.rb;
		case (i_instr.rFmt.opcode)
			OP_ADD: begin
				nFlagEn = 1'b1;
				nRfWe = 1'b1;
				nCond = i_instr.rFmt.cond;
			end
			OP_NDU: begin
				nAluNand = 1'b1;
				nFlagEn = 1'b1;
				nRfWe = 1'b1;
				nCond = i_instr.rFmt.cond;
			end
			OP_ADI: begin
				nUseImm = 1'b1;
				nFlagEn = 1'b1;
				nRfWe = 1'b1;
				nDest = i_instr.iFmt.rb; // ADI writes rb.
			end
			OP_LHI: begin
				nWbSel = WB_IMM;
				nRfWe = 1'b1;
				nDest = i_instr.jFmt.ra;
			end
			OP_LW, OP_SW: begin
				nUseImm = 1'b1;
				nWbSel = WB_MEM;
				nRfWe = (i_instr.iFmt.opcode == OP_LW);
				nMemWe = (i_instr.iFmt.opcode == OP_SW);
				nDest = i_instr.iFmt.ra;
				o_rdAddrA = i_instr.iFmt.rb; // Base register feeds the adder.
				o_rdAddrB = i_instr.iFmt.ra; // Store data.
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ctl.aluNand <= 1'b0;
			ctl.useImm <= 1'b0;
			ctl.flagEn <= 1'b0;
			ctl.cond <= COND_ALWAYS;
			ctl.wbSel <= WB_ALU;
			ctl.rfWe <= 1'b0;
			ctl.memWe <= 1'b0;
			ctl.destAddr <= '0;
		end else if (stg.read) begin
			ctl.aluNand <= nAluNand;
			ctl.useImm <= nUseImm;
			ctl.flagEn <= nFlagEn;
			ctl.cond <= nCond;
			ctl.wbSel <= nWbSel;
			ctl.rfWe <= nRfWe;
			ctl.memWe <= nMemWe;
			ctl.destAddr <= nDest;
		end
	end

	always_ff @(posedge clk) begin
		if (stg.read) begin
			o_imm <= (i_instr.jFmt.opcode == OP_LHI) ? immHigh : immSext;
		end
	end

endmodule

`default_nettype wire

// File: logic/executeUnit.sv
`default_nettype none

module executeUnit (
	input logic clk,
	input logic rst,
	stageIf.unit stg,
	ctrlIf.exe ctl,
	input logic [riscPkg::DATA_W-1:0] i_opA,
	input logic [riscPkg::DATA_W-1:0] i_opB,
	input logic [riscPkg::DATA_W-1:0] i_imm,
	input logic [riscPkg::DATA_W-1:0] i_memRdata,
	output logic [riscPkg::DATA_W-1:0] o_addr,
	output logic [riscPkg::DATA_W-1:0] o_storeData,
	output logic o_memWe,
	output logic o_rfWe,
	output logic [riscPkg::REG_AW-1:0] o_wrAddr,
	output logic [riscPkg::DATA_W-1:0] o_wrData
);
	import riscPkg::*;

	logic [DATA_W-1:0] opAReg, opBReg, aluB, aluNext, aluRes;
	logic [DATA_W:0] sum; // Extra bit is the carry out.
	logic carryFlag, zeroFlag, condNext, condOk;

	always_ff @(posedge clk) begin
		if (stg.read) begin
			opAReg <= i_opA;
			opBReg <= i_opB;
		end
		if (stg.exec) begin
			aluRes <= aluNext;
		end
	end

	assign aluB = ctl.useImm ? i_imm : opBReg;
	assign sum = {1'b0, opAReg} + {1'b0, aluB};
	assign aluNext = ctl.aluNand ? ~(opAReg & aluB) : sum[DATA_W-1:0];

	always_comb begin
		case (ctl.cond)
			COND_ALWAYS: condNext = 1'b1;
			COND_ZERO: condNext = zeroFlag; // Flags from before this instruction.
			COND_CARRY: condNext = carryFlag;
			default: condNext = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			carryFlag <= 1'b0;
			zeroFlag <= 1'b0;
			condOk <= 1'b0;
		end else if (stg.exec) begin
			condOk <= condNext;
			if (ctl.flagEn) begin
				carryFlag <= ctl.aluNand ? 1'b0 : sum[DATA_W]; // NAND clears carry.
				zeroFlag <= (aluNext == '0);
			end
		end
	end

	assign o_addr = aluRes; // Base plus offset for LW and SW.
	assign o_storeData = opBReg;
	assign o_memWe = stg.mem & ctl.memWe;
	assign o_rfWe = stg.wb & ctl.rfWe & condOk;
	assign o_wrAddr = ctl.destAddr;
	assign o_wrData = (ctl.wbSel == WB_IMM) ? i_imm :
		(ctl.wbSel == WB_MEM) ? i_memRdata : aluRes;

	// Decoder never marks one instruction as both a load-type write and a store.
	noDualWrite: assert property (@(posedge clk) disable iff (rst)
		!(ctl.memWe && ctl.rfWe));

endmodule

`default_nettype wire

// File: logic/fetchUnit.sv
`default_nettype none

module fetchUnit #(
	parameter int IMEM_AW = 6
) (
	input logic clk,
	input logic i_progWe,
	input logic [IMEM_AW-1:0] i_progAddr,
	input riscPkg::instrWord_u i_progData,
	input logic i_running,
	input logic [IMEM_AW-1:0] i_pc,
	stageIf.unit stg,
	output riscPkg::instrWord_u o_instr
);
	import riscPkg::*;

	instrWord_u progStore [2**IMEM_AW]; // Program words.

	always_ff @(posedge clk) begin
		if (i_progWe && !i_running) begin
			progStore[i_progAddr] <= i_progData; // Loads ignored mid-run.
		end
	end

	always_ff @(posedge clk) begin
		if (stg.fetch) begin
			o_instr <= progStore[i_pc]; // Held for the rest of the instruction.
		end
	end

endmodule

`default_nettype wire

// File: logic/programCounter.sv
`default_nettype none

module programCounter #(
	parameter int IMEM_AW = 6
) (
	input logic clk,
	input logic rst,
	input logic i_start,
	input logic [IMEM_AW:0] i_progLen,
	stageIf.unit stg,
	output logic [IMEM_AW-1:0] o_pc,
	output logic o_last
);

	logic [IMEM_AW:0] lenReg; // Program length taken at start.

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_pc <= '0;
			lenReg <= '0;
		end else if (i_start) begin
			o_pc <= '0; // Programs always run from address 0.
			lenReg <= i_progLen;
		end else if (stg.wb) begin
			o_pc <= o_pc + 1'b1; // Step once per retired instruction.
		end
	end

	assign o_last = ({1'b0, o_pc} == lenReg - 1'b1);

	// Sequencer must stop on o_last, so the count never runs beyond the length.
	pcInRange: assert property (@(posedge clk) disable iff (rst)
		stg.wb |=> ({1'b0, o_pc} <= lenReg));

endmodule

`default_nettype wire

// File: logic/regFile.sv
`default_nettype none

module regFile (
	input logic clk,
	input logic rst,
	input logic [riscPkg::REG_AW-1:0] i_rdAddrA,
	input logic [riscPkg::REG_AW-1:0] i_rdAddrB,
	output logic [riscPkg::DATA_W-1:0] o_rdDataA,
	output logic [riscPkg::DATA_W-1:0] o_rdDataB,
	input logic i_we,
	input logic [riscPkg::REG_AW-1:0] i_wrAddr,
	input logic [riscPkg::DATA_W-1:0] i_wrData
);
	import riscPkg::*;

	logic [DATA_W-1:0] regs [2**REG_AW]; // R0 to R7, all general purpose.

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 2**REG_AW; i++) begin
				regs[i] <= '0; // Programs may read untouched registers.
			end
		end else if (i_we) begin
			regs[i_wrAddr] <= i_wrData;
		end
	end

	assign o_rdDataA = regs[i_rdAddrA]; // Asynchronous read.
	assign o_rdDataB = regs[i_rdAddrB];

endmodule

`default_nettype wire

// File: logic/riscCore.sv
`default_nettype none

module riscCore #(
	parameter int IMEM_AW = 6,
	parameter int DMEM_AW = 8
) (
	input logic clk,
	input logic rst,
	input logic i_progWe,
	input logic [IMEM_AW-1:0] i_progAddr,
	input logic [riscPkg::DATA_W-1:0] i_progData,
	input logic [IMEM_AW:0] i_progLen,
	input logic i_start,
	output logic o_rfWe,
	output logic [riscPkg::REG_AW-1:0] o_rfAddr,
	output logic [riscPkg::DATA_W-1:0] o_rfData,
	output logic o_memWe,
	output logic [DMEM_AW-1:0] o_memAddr,
	output logic [riscPkg::DATA_W-1:0] o_memData,
	output logic o_done
);
	import riscPkg::*;

	stageIf stg ();
	ctrlIf ctl ();

	logic running, last;
	logic [IMEM_AW-1:0] pc;
	instrWord_u instr;
	logic [REG_AW-1:0] rdAddrA, rdAddrB;
	logic [DATA_W-1:0] rdDataA, rdDataB, imm, memRdata, aluAddr;

	assign running = stg.fetch | stg.read | stg.exec | stg.mem | stg.wb; // Blocks program loads.
	assign o_memAddr = aluAddr[DMEM_AW-1:0]; // Upper sum bits do not reach the RAM.

	stageSequencer seq0 (.clk(clk), .rst(rst), .i_start(i_start), .i_last(last),
		.o_done(o_done), .stg(stg.seq));

	programCounter #(.IMEM_AW(IMEM_AW)) pc0 (.clk(clk), .rst(rst), .i_start(i_start),
		.i_progLen(i_progLen), .stg(stg.unit), .o_pc(pc), .o_last(last));

	fetchUnit #(.IMEM_AW(IMEM_AW)) fetch0 (.clk(clk), .i_progWe(i_progWe),
		.i_progAddr(i_progAddr), .i_progData(i_progData), .i_running(running),
		.i_pc(pc), .stg(stg.unit), .o_instr(instr));

	decodeUnit dec0 (.clk(clk), .rst(rst), .i_instr(instr), .stg(stg.unit), .ctl(ctl.dec),
		.o_rdAddrA(rdAddrA), .o_rdAddrB(rdAddrB), .o_imm(imm));

	regFile rf0 (.clk(clk), .rst(rst), .i_rdAddrA(rdAddrA), .i_rdAddrB(rdAddrB),
		.o_rdDataA(rdDataA), .o_rdDataB(rdDataB), .i_we(o_rfWe), .i_wrAddr(o_rfAddr),
		.i_wrData(o_rfData));

	executeUnit exe0 (.clk(clk), .rst(rst), .stg(stg.unit), .ctl(ctl.exe),
		.i_opA(rdDataA), .i_opB(rdDataB), .i_imm(imm), .i_memRdata(memRdata),
		.o_addr(aluAddr), .o_storeData(o_memData), .o_memWe(o_memWe), .o_rfWe(o_rfWe),
		.o_wrAddr(o_rfAddr), .o_wrData(o_rfData));

	dataMemory #(.DMEM_AW(DMEM_AW)) dmem0 (.clk(clk), .stg(stg.unit), .i_we(o_memWe),
		.i_addr(o_memAddr), .i_wdata(o_memData), .o_rdata(memRdata));

endmodule

`default_nettype wire

// File: logic/riscPkg.sv
`default_nettype none

package riscPkg;

	localparam int DATA_W = 16; // Word width.
	localparam int REG_AW = 3; // Eight registers.
	localparam int OPC_W = 4; // Opcode field width.

	localparam logic [OPC_W-1:0] OP_ADD = 4'b0000; // rc = ra + rb.
	localparam logic [OPC_W-1:0] OP_ADI = 4'b0001; // rb = ra + imm6.
	localparam logic [OPC_W-1:0] OP_NDU = 4'b0010; // rc = ~(ra & rb).
	localparam logic [OPC_W-1:0] OP_LHI = 4'b0011; // ra = imm9 << 7.
	localparam logic [OPC_W-1:0] OP_LW = 4'b0100; // ra = mem[rb + imm6].
	localparam logic [OPC_W-1:0] OP_SW = 4'b0101; // mem[rb + imm6] = ra.

	localparam logic [1:0] COND_ALWAYS = 2'b00; // Unconditional write.
	localparam logic [1:0] COND_ZERO = 2'b01; // Write if zero flag set.
	localparam logic [1:0] COND_CARRY = 2'b10; // Write if carry flag set.
	// Code 11 is left undefined and blocks the write.

	localparam logic [1:0] WB_ALU = 2'b00; // ALU result.
	localparam logic [1:0] WB_IMM = 2'b01; // Shifted immediate.
	localparam logic [1:0] WB_MEM = 2'b10; // Load data.

	typedef union packed {
		struct packed {
			logic [OPC_W-1:0] opcode; // Operation.
			logic [REG_AW-1:0] ra; // First source.
			logic [REG_AW-1:0] rb; // Second source.
			logic [REG_AW-1:0] rc; // Destination.
			logic unused; // Spare bit.
			logic [1:0] cond; // Write condition.
		} rFmt;
		struct packed {
			logic [OPC_W-1:0] opcode; // Operation.
			logic [REG_AW-1:0] ra; // Source or load target.
			logic [REG_AW-1:0] rb; // Base or ADI target.
			logic [5:0] imm6; // Signed offset.
		} iFmt;
		struct packed {
			logic [OPC_W-1:0] opcode; // Operation.
			logic [REG_AW-1:0] ra; // Destination.
			logic [8:0] imm9; // Upper immediate.
		} jFmt;
	} instrWord_u;

endpackage

`default_nettype wire

// File: logic/stageSequencer.sv
`default_nettype none

module stageSequencer (
	input logic clk,
	input logic rst,
	input logic i_start,
	input logic i_last,
	output logic o_done,
	stageIf.seq stg
);

	typedef enum logic [2:0] {
		stIdle,
		stFetch,
		stRead,
		stExec,
		stMem,
		stWb,
		stDone
	} seqState_e;

	seqState_e state;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle, stDone: if (i_start) state <= stFetch; // Start only when not busy.
				stFetch: state <= stRead;
				stRead: state <= stExec;
				stExec: state <= stMem;
				stMem: state <= stWb;
				stWb: state <= i_last ? stDone : stFetch; // Stop after the last instruction.
				default: state <= stIdle;
			endcase
		end
	end

	assign stg.fetch = (state == stFetch);
	assign stg.read = (state == stRead);
	assign stg.exec = (state == stExec);
	assign stg.mem = (state == stMem);
	assign stg.wb = (state == stWb);
	assign o_done = (state == stDone); // Held until the next start.

	// A start in mid-run would clear the PC under a running instruction.
	startWhenIdle: assert property (@(posedge clk) disable iff (rst)
		i_start |-> (state == stIdle || state == stDone));

endmodule

`default_nettype wire

// File: riscCore.f
logic/riscPkg.sv
logic/coreIfs.sv
logic/stageSequencer.sv
logic/programCounter.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/regFile.sv
logic/executeUnit.sv
logic/dataMemory.sv
logic/riscCore.sv
tests/riscCoreTb.sv

// File: tests/riscCoreTb.sv
`default_nettype none

module riscCoreTb;
	import riscPkg::*;

	localparam int IMEM_AW = 6;
	localparam int DMEM_AW = 8;
	localparam int NROWS = 5;
	localparam int NWORDS = 34;

	logic clk, rst, progWe, start, rfWe, memWe, done;
	logic [IMEM_AW-1:0] progAddr;
	logic [IMEM_AW:0] progLen;
	logic [DATA_W-1:0] progData, rfData, memData;
	logic [REG_AW-1:0] rfAddr;
	logic [DMEM_AW-1:0] memAddr;

	int rowLen [NROWS] = '{8, 9, 8, 6, 3}; // Instructions per program.
	bit rowRand [NROWS] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0}; // Random ADI immediates.
	logic [DATA_W-1:0] progWords [NWORDS] = '{
		16'h04C8, 16'h33FF, 16'h3500, 16'h0298, // Row 0: reads of zero regs, LHI, carry out.
		16'h1700, 16'h1940, 16'h22F0, 16'h11C0, // ADI chain, NDU, ADI from r0.
		16'h1040, 16'h0651, 16'h06E1, 16'h3DFF, // Row 1: set zero, ADD if zero twice, LHI.
		16'h0DAA, 16'h2CAA, 16'h003B, 16'h0439, // ADD if carry, NDU if carry, code 11, ADD if zero.
		16'hF000, // Unknown opcode.
		16'h32AB, 16'h1090, 16'h5283, 16'h5EBF, // Row 2: LHI, base 16, two stores.
		16'h4683, 16'h48BF, 16'h5980, 16'h4B80, // Loads back, store to truncated address, load.
		16'h1240, 16'h1280, 16'h029A, 16'h26A1, // Row 3: random ADIs, ADD if carry, NDU if zero.
		16'h5805, 16'h4C05, // Store then load at address 5.
		16'h0B88, 16'h52C0, 16'h1FFE // Row 4: short program on leftover registers.
	};

	logic [DATA_W-1:0] mRegs [2**REG_AW]; // Reference register file.
	logic [DATA_W-1:0] mMem [2**DMEM_AW]; // Reference data RAM.
	logic mCarry, mZero;
	bit expIsMem [$]; // Predicted write events in order.
	int expAddr [$];
	logic [DATA_W-1:0] expData [$];
	int valErrs, otherErrs, seed;

	riscCore #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) dut0 (.clk(clk), .rst(rst),
		.i_progWe(progWe), .i_progAddr(progAddr), .i_progData(progData), .i_progLen(progLen),
		.i_start(start), .o_rfWe(rfWe), .o_rfAddr(rfAddr), .o_rfData(rfData), .o_memWe(memWe),
		.o_memAddr(memAddr), .o_memData(memData), .o_done(done));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic expectWrite(input bit isMem, input int addr, input logic [DATA_W-1:0] data);
		if (!isMem) mRegs[addr] = data; // Model register file follows its own writes.
		expIsMem.push_back(isMem);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	task automatic modelStep(input instrWord_u w);
		logic [DATA_W:0] sum;
		logic [DATA_W-1:0] opA, opB, res, sext;
		logic [DMEM_AW-1:0] addr;
		logic wrOk;
		sext = {{(DATA_W - 6){w.iFmt.imm6[5]}}, w.iFmt.imm6}; // Signed imm6.
		case (w.rFmt.opcode)
			OP_ADD, OP_NDU: begin
				opA = mRegs[w.rFmt.ra];
				opB = mRegs[w.rFmt.rb];
				wrOk = (w.rFmt.cond == COND_ALWAYS) || (w.rFmt.cond == COND_ZERO && mZero)
					|| (w.rFmt.cond == COND_CARRY && mCarry); // Flags before this instruction.
				sum = {1'b0, opA} + {1'b0, opB};
				res = (w.rFmt.opcode == OP_NDU) ? ~(opA & opB) : sum[DATA_W-1:0];
				mCarry = (w.rFmt.opcode == OP_ADD) && sum[DATA_W]; // NDU clears carry.
				mZero = (res == '0); // Flags move even without a write.
				if (wrOk) expectWrite(1'b0, int'(w.rFmt.rc), res);
			end
			OP_ADI: begin
				sum = {1'b0, mRegs[w.iFmt.ra]} + {1'b0, sext};
				mCarry = sum[DATA_W];
				mZero = (sum[DATA_W-1:0] == '0);
				expectWrite(1'b0, int'(w.iFmt.rb), sum[DATA_W-1:0]);
			end
			OP_LHI: expectWrite(1'b0, int'(w.jFmt.ra), {w.jFmt.imm9, 7'b0});
			OP_LW, OP_SW: begin
				sum = {1'b0, mRegs[w.iFmt.rb]} + {1'b0, sext};
				addr = sum[DMEM_AW-1:0]; // Only the low address bits reach the RAM.
				if (w.iFmt.opcode == OP_LW) begin
					expectWrite(1'b0, int'(w.iFmt.ra), mMem[addr]);
				end else begin
					mMem[addr] = mRegs[w.iFmt.ra];
					expectWrite(1'b1, int'(addr), mRegs[w.iFmt.ra]);
				end
			end
			default: ; // No-op.
		endcase
	endtask

	task automatic checkRfWrite(input logic [REG_AW-1:0] gotA, input logic [DATA_W-1:0] gotD,
		input logic [REG_AW-1:0] expA, input logic [DATA_W-1:0] expD);
		if (gotA !== expA || gotD !== expD) begin
			$display("ERR %0t: register write r%0d=%h, expected r%0d=%h",
				$time, gotA, gotD, expA, expD);
			valErrs++;
		end
	endtask

	task automatic checkMemWrite(input logic [DMEM_AW-1:0] gotA, input logic [DATA_W-1:0] gotD,
		input logic [DMEM_AW-1:0] expA, input logic [DATA_W-1:0] expD);
		if (gotA !== expA || gotD !== expD) begin
			$display("ERR %0t: store mem[%h]=%h, expected mem[%h]=%h",
				$time, gotA, gotD, expA, expD);
			valErrs++;
		end
	endtask

	task automatic checkCycles(input int got, input int exp);
		if (got != exp) begin
			$display("ERR %0t: done after %0d cycles, expected %0d", $time, got, exp);
			valErrs++;
		end
	endtask

	task automatic checkLevel(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
			valErrs++;
		end
	endtask

	task automatic observeCycle(input int cycle);
		if (rfWe && memWe) begin
			$display("Register write and store in the same cycle at %0t", $time);
			otherErrs++;
		end
		if (rfWe) begin
			if (cycle % 5 != 0) begin
				$display("Register write outside a write-back cycle at %0t", $time);
				otherErrs++;
			end
			if (expIsMem.size() == 0 || expIsMem[0]) begin
				$display("Extra register write to r%0d at %0t", rfAddr, $time);
				otherErrs++;
			end else begin
				expIsMem.delete(0);
				checkRfWrite(rfAddr, rfData, REG_AW'(expAddr.pop_front()), expData.pop_front());
			end
		end
		if (memWe) begin
			if (cycle % 5 != 4) begin
				$display("Store outside a memory cycle at %0t", $time);
				otherErrs++;
			end
			if (expIsMem.size() == 0 || !expIsMem[0]) begin
				$display("Extra store to address %h at %0t", memAddr, $time);
				otherErrs++;
			end else begin
				expIsMem.delete(0);
				checkMemWrite(memAddr, memData, DMEM_AW'(expAddr.pop_front()), expData.pop_front());
			end
		end
	endtask

	task automatic runRow(input int row, input int base);
		logic [DATA_W-1:0] word;
		int rnd, cycles;
		for (int i = 0; i < rowLen[row]; i++) begin
			word = progWords[base + i];
			if (rowRand[row] && word[15:12] == OP_ADI) begin
				rnd = $random(seed);
				word[5:0] = rnd[5:0]; // Fresh imm6 for each ADI.
			end
			modelStep(word);
			@(posedge clk);
			progWe <= 1'b1;
			progAddr <= IMEM_AW'(i);
			progData <= word;
		end
		@(posedge clk);
		progWe <= 1'b0;
		progLen <= (IMEM_AW + 1)'(rowLen[row]);
		start <= 1'b1; // Cycles count from this edge.
		cycles = 0;
		do begin
			@(posedge clk);
			start <= 1'b0;
			cycles++;
			@(negedge clk);
			observeCycle(cycles);
		end while (!done);
		checkCycles(cycles, 5 * rowLen[row] + 1);
		if (expIsMem.size() != 0) begin
			$display("Program %0d finished with %0d predicted writes missing", row, expIsMem.size());
			otherErrs++;
			expIsMem.delete();
			expAddr.delete();
			expData.delete();
		end
	endtask

	initial begin
		int total;
		total = 0;
		foreach (rowLen[r]) total += rowLen[r];
		#((total * 5 + 20 * NROWS) * 20); // Generous bound on the whole run.
		$display("Timeout: the core did not finish all programs in time");
		$display("Test failed");
		$finish;
	end

	initial begin
		int base;
		seed = 32'h867db56b;
		valErrs = 0;
		otherErrs = 0;
		rst = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		progLen = '0;
		start = 1'b0;
		mCarry = 1'b0;
		mZero = 1'b0;
		foreach (mRegs[i]) mRegs[i] = '0; // Registers clear on reset.
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		checkLevel("o_done", done, 1'b0);
		checkLevel("o_rfWe", rfWe, 1'b0);
		checkLevel("o_memWe", memWe, 1'b0);
		base = 0;
		for (int row = 0; row < NROWS; row++) begin
			runRow(row, base); // Model state carries across rows.
			base += rowLen[row];
		end
		$display("Errors: %0d wrong values, %0d other failures", valErrs, otherErrs);
		if (valErrs + otherErrs == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
